/* logic/wormhole_pkg.sv */
// wormhole concentrator package
// flit and header field widths, link typedefs and the input-control
// state encoding shared by every stage

package wormhole_pkg;

  // flit and header field widths
  localparam int flit_width_lp = 32;
  localparam int cord_width_lp = 8;
  localparam int len_width_lp  = 4;
  localparam int cid_width_lp  = 4;

  // cid can address at most this many links
  localparam int max_links_lp = 1 << cid_width_lp;

  // header field positions in the low bits of a flit
  localparam int cord_lsb_lp = 0;
  localparam int len_lsb_lp  = cord_lsb_lp + cord_width_lp;
  localparam int cid_lsb_lp  = len_lsb_lp + len_width_lp;

  typedef logic [flit_width_lp-1:0] flit_t;
  typedef logic [cord_width_lp-1:0] cord_t;
  // number of body flits that follow the header
  typedef logic [len_width_lp-1:0]  len_t;
  // destination link on the egress side
  typedef logic [cid_width_lp-1:0]  cid_t;

  // input control waits for a header or walks through body flits
  typedef enum logic
  {
    HEADER_ST,
    BODY_ST
  } wormhole_state_e;

endpackage

/* logic/wormhole_two_fifo.sv */
// wormhole two-entry buffer
// registers one link input so that ready depends only on local state,
// head is consumed with yumi

module wormhole_two_fifo
  import wormhole_pkg::*;
  (input  logic  clk_i
  ,input  logic  reset_i

  // link side, valid with ready_and
  ,input  logic  v_i
  ,input  flit_t data_i
  ,output logic  ready_o

  // head side
  ,output logic  v_o
  ,output flit_t data_o
  ,input  logic  yumi_i
  );

  // two storage slots, no reset on payload
  flit_t mem_r [0:1];

  logic wptr_r;
  logic rptr_r;
  logic full_r;
  logic ready_r;

  logic empty;
  logic enq;
  logic deq;
  logic full_n;

  // equal pointers mean empty unless the full flag is set
  assign empty = (wptr_r == rptr_r) & ~full_r;
  assign enq   = v_i & ready_r;
  // yumi only comes with a valid head
  assign deq   = yumi_i;

  always_comb
  begin
    full_n = full_r;
    if (enq & ~deq)
    begin
      // write closes the gap to the read pointer
      full_n = (~wptr_r == rptr_r);
    end
    else if (deq & ~enq)
    begin
      full_n = 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr_r  <= 1'b0;
      rptr_r  <= 1'b0;
      full_r  <= 1'b0;
      ready_r <= 1'b0;
    end
    else
    begin
      wptr_r  <= wptr_r ^ enq;
      rptr_r  <= rptr_r ^ deq;
      full_r  <= full_n;
      // ready is registered, low while full
      ready_r <= ~full_n;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
    begin
      mem_r[wptr_r] <= data_i;
    end
  end

  assign ready_o = ready_r;
  assign v_o     = ~empty;
  assign data_o  = mem_r[rptr_r];

endmodule

/* logic/wormhole_input_control.sv */
// wormhole input control
// follows header and body flits of the packet at one FIFO head,
// requests the decoded destination and pulses release on the tail

module wormhole_input_control
  import wormhole_pkg::*;
  #(parameter int num_links_p = 4)
  (input  logic                   clk_i
  ,input  logic                   reset_i

  ,input  logic                   fifo_v_i
  ,input  logic                   fifo_yumi_i
  // header fields of the flit at the FIFO head
  ,input  cid_t                   dest_i
  ,input  len_t                   len_i

  ,output logic [num_links_p-1:0] reqs_o
  ,output logic                   release_o
  );

  wormhole_state_e state_r;
  // body flits still to go
  len_t            count_r;
  // destination held for the body of the packet
  logic [num_links_p-1:0] reqs_r;

  logic [max_links_lp-1:0] dest_decode;
  logic [num_links_p-1:0]  dest_onehot;

  // full cid decode, keep only the links that exist
  assign dest_decode = max_links_lp'(1) << dest_i;
  assign dest_onehot = dest_decode[num_links_p-1:0];

  // header requests only while it is valid, body keeps the held path
  assign reqs_o = (state_r == BODY_ST) ? reqs_r : (fifo_v_i ? dest_onehot : '0);

  // tail is the header itself when len is zero
  assign release_o = fifo_yumi_i
                   & ((state_r == HEADER_ST) ? (len_i == '0) : (count_r == len_t'(1)));

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= HEADER_ST;
      count_r <= '0;
      reqs_r  <= '0;
    end
    else
    begin
      case (state_r)
        HEADER_ST:
        begin
          // header with a body behind it opens the wormhole
          if (fifo_yumi_i && (len_i != '0))
          begin
            state_r <= BODY_ST;
            count_r <= len_i;
            reqs_r  <= dest_onehot;
          end
        end
        BODY_ST:
        begin
          if (fifo_yumi_i)
          begin
            count_r <= count_r - len_t'(1);
            if (count_r == len_t'(1))
            begin
              state_r <= HEADER_ST;
            end
          end
        end
        default:
        begin
          state_r <= HEADER_ST;
        end
      endcase
    end
  end

endmodule

/* logic/wormhole_output_control.sv */
// wormhole output control
// round-robin arbiter over the requesting inputs, the grant locks
// until the granted packet releases, drives valid, yumi and data select

module wormhole_output_control
  import wormhole_pkg::*;
  #(parameter int num_links_p = 4)
  (input  logic                   clk_i
  ,input  logic                   reset_i

  ,input  logic [num_links_p-1:0] reqs_i
  ,input  logic [num_links_p-1:0] release_i
  ,input  logic [num_links_p-1:0] valid_i
  ,input  logic                   ready_and_i

  ,output logic                   valid_o
  ,output logic [num_links_p-1:0] yumi_o
  // one-hot data select
  ,output logic [num_links_p-1:0] sel_o
  );

  localparam int idx_width_lp = (num_links_p > 1) ? $clog2(num_links_p) : 1;

  logic [num_links_p-1:0]  grant_r;
  logic [idx_width_lp-1:0] last_idx_r;

  logic [num_links_p-1:0]  arb_grant;
  logic [num_links_p-1:0]  grant;
  logic [idx_width_lp-1:0] arb_idx;
  logic                    arb_found;
  logic                    locked;
  logic                    done;
  int                      cand_idx;

  // candidate index offset places after the last winner
  function automatic int rr_next(input int last, input int offset);
    int idx;
    idx = last + offset;
    if (idx >= num_links_p)
    begin
      idx = idx - num_links_p;
    end
    return idx;
  endfunction

  // search starts just after the last granted index
  always_comb
  begin
    arb_grant = '0;
    arb_idx   = last_idx_r;
    arb_found = 1'b0;
    cand_idx  = 0;
    for (int k = 1; k <= num_links_p; k++)
    begin
      cand_idx = rr_next(int'(last_idx_r), k);
      if (!arb_found && reqs_i[cand_idx])
      begin
        arb_found           = 1'b1;
        arb_grant[cand_idx] = 1'b1;
        arb_idx             = idx_width_lp'(cand_idx);
      end
    end
  end

  // a new header wins in the same cycle it shows up, no bubble
  assign locked = |grant_r;
  assign grant  = locked ? grant_r : arb_grant;

  assign valid_o = |(grant & valid_i);
  assign yumi_o  = (valid_o & ready_and_i) ? grant : '0;
  assign sel_o   = grant;

  // release of the granted input frees the output after this cycle
  assign done = |(grant & release_i);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      grant_r    <= '0;
      // so that index 0 is first after reset
      last_idx_r <= idx_width_lp'(num_links_p - 1);
    end
    else
    begin
      grant_r <= done ? '0 : grant;
      if (!locked && arb_found)
      begin
        last_idx_r <= arb_idx;
      end
    end
  end

endmodule

/* logic/wormhole_concentrator_in.sv */
// wormhole concentrator ingress stage
// merges num_links_p wormhole links onto one concentrated link,
// round robin at packet granularity, one cycle through

module wormhole_concentrator_in
  import wormhole_pkg::*;
  #(parameter int num_links_p = 4)
  (input  logic                    clk_i
  ,input  logic                    reset_i

  // unconcentrated links
  ,input  logic [num_links_p-1:0]  in_v_i
  ,input  flit_t [num_links_p-1:0] in_data_i
  ,output logic [num_links_p-1:0]  in_ready_and_o

  // concentrated link
  ,output logic                    conc_v_o
  ,output flit_t                   conc_data_o
  ,input  logic                    conc_ready_and_i
  );

  flit_t [num_links_p-1:0] fifo_data;
  logic [num_links_p-1:0]  fifo_v;
  // per-link yumi from the single output control
  logic [num_links_p-1:0]  fifo_yumi;
  logic [num_links_p-1:0]  reqs;
  logic [num_links_p-1:0]  releases;
  logic [num_links_p-1:0]  sel;

  for (genvar i = 0; i < num_links_p; i++)
  begin : link
    wormhole_two_fifo fifo
      (.clk_i   (clk_i)
      ,.reset_i (reset_i)
      ,.v_i     (in_v_i[i])
      ,.data_i  (in_data_i[i])
      ,.ready_o (in_ready_and_o[i])
      ,.v_o     (fifo_v[i])
      ,.data_o  (fifo_data[i])
      ,.yumi_i  (fifo_yumi[i])
      );

    // only one destination here, so cid is not looked at
    wormhole_input_control #(.num_links_p(1)) ic
      (.clk_i       (clk_i)
      ,.reset_i     (reset_i)
      ,.fifo_v_i    (fifo_v[i])
      ,.fifo_yumi_i (fifo_yumi[i])
      ,.dest_i      (cid_t'(0))
      ,.len_i       (fifo_data[i][len_lsb_lp +: len_width_lp])
      ,.reqs_o      (reqs[i])
      ,.release_o   (releases[i])
      );
  end

  // the one concentrated output arbitrates over all links
  wormhole_output_control #(.num_links_p(num_links_p)) oc
    (.clk_i       (clk_i)
    ,.reset_i     (reset_i)
    ,.reqs_i      (reqs)
    ,.release_i   (releases)
    ,.valid_i     (fifo_v)
    ,.ready_and_i (conc_ready_and_i)
    ,.valid_o     (conc_v_o)
    ,.yumi_o      (fifo_yumi)
    ,.sel_o       (sel)
    );

  // and-or mux on the one-hot grant
  always_comb
  begin
    conc_data_o = '0;
    for (int i = 0; i < num_links_p; i++)
    begin
      if (sel[i])
      begin
        conc_data_o = conc_data_o | fifo_data[i];
      end
    end
  end

endmodule

/* logic/wormhole_concentrator_out.sv */
// wormhole concentrator egress stage
// fans the concentrated link out to num_links_p links,
// destination taken from the header cid, one cycle through

module wormhole_concentrator_out
  import wormhole_pkg::*;
  #(parameter int num_links_p = 4)
  (input  logic                    clk_i
  ,input  logic                    reset_i

  // concentrated link
  ,input  logic                    conc_v_i
  ,input  flit_t                   conc_data_i
  ,output logic                    conc_ready_and_o

  // unconcentrated links
  ,output logic [num_links_p-1:0]  out_v_o
  ,output flit_t [num_links_p-1:0] out_data_o
  ,input  logic [num_links_p-1:0]  out_ready_and_i
  );

  flit_t fifo_data;
  logic  fifo_v;
  logic  any_yumi;
  // release goes to every output, only the granted one acts on it
  logic  release_all;

  logic [num_links_p-1:0] reqs;
  logic [num_links_p-1:0] yumis;

  assign any_yumi = |yumis;

  wormhole_two_fifo fifo
    (.clk_i   (clk_i)
    ,.reset_i (reset_i)
    ,.v_i     (conc_v_i)
    ,.data_i  (conc_data_i)
    ,.ready_o (conc_ready_and_o)
    ,.v_o     (fifo_v)
    ,.data_o  (fifo_data)
    ,.yumi_i  (any_yumi)
    );

  wormhole_input_control #(.num_links_p(num_links_p)) ic
    (.clk_i       (clk_i)
    ,.reset_i     (reset_i)
    ,.fifo_v_i    (fifo_v)
    ,.fifo_yumi_i (any_yumi)
    ,.dest_i      (fifo_data[cid_lsb_lp +: cid_width_lp])
    ,.len_i       (fifo_data[len_lsb_lp +: len_width_lp])
    ,.reqs_o      (reqs)
    ,.release_o   (release_all)
    );

  for (genvar i = 0; i < num_links_p; i++)
  begin : out_link
    // single requester per output, the arbiter only does the locking
    wormhole_output_control #(.num_links_p(1)) oc
      (.clk_i       (clk_i)
      ,.reset_i     (reset_i)
      ,.reqs_i      (reqs[i])
      ,.release_i   (release_all)
      ,.valid_i     (fifo_v)
      ,.ready_and_i (out_ready_and_i[i])
      ,.valid_o     (out_v_o[i])
      ,.yumi_o      (yumis[i])
      ,.sel_o       ()
      );

    // head broadcast, valid marks the one link it is for
    assign out_data_o[i] = fifo_data;
  end

endmodule

/* logic/wormhole_concentrator_top.sv */
// wormhole concentrator pair
// ingress stage merges the links onto one internal concentrated link,
// egress stage fans it back out by header cid

module wormhole_concentrator_top
  import wormhole_pkg::*;
  #(parameter int num_links_p = 4)
  (input  logic                    clk_i
  ,input  logic                    reset_i

  // links into the ingress stage
  ,input  logic [num_links_p-1:0]  in_v_i
  ,input  flit_t [num_links_p-1:0] in_data_i
  ,output logic [num_links_p-1:0]  in_ready_and_o

  // links out of the egress stage
  ,output logic [num_links_p-1:0]  out_v_o
  ,output flit_t [num_links_p-1:0] out_data_o
  ,input  logic [num_links_p-1:0]  out_ready_and_i
  );

  // internal concentrated link
  logic  conc_v;
  flit_t conc_data;
  logic  conc_ready_and;

  wormhole_concentrator_in #(.num_links_p(num_links_p)) conc_in
    (.clk_i            (clk_i)
    ,.reset_i          (reset_i)
    ,.in_v_i           (in_v_i)
    ,.in_data_i        (in_data_i)
    ,.in_ready_and_o   (in_ready_and_o)
    ,.conc_v_o         (conc_v)
    ,.conc_data_o      (conc_data)
    ,.conc_ready_and_i (conc_ready_and)
    );

  wormhole_concentrator_out #(.num_links_p(num_links_p)) conc_out
    (.clk_i            (clk_i)
    ,.reset_i          (reset_i)
    ,.conc_v_i         (conc_v)
    ,.conc_data_i      (conc_data)
    ,.conc_ready_and_o (conc_ready_and)
    ,.out_v_o          (out_v_o)
    ,.out_data_o       (out_data_o)
    ,.out_ready_and_i  (out_ready_and_i)
    );

endmodule

/* sim/wormhole_concentrator_assertions.sv */
// wormhole concentrator handshake assertions
// output links hold valid and data until ready, stay quiet in reset,
// and only one output is valid at a time

module wormhole_concentrator_assertions
  import wormhole_pkg::*;
  #(parameter int num_links_p = 4)
  (input  logic                    clk_i
  ,input  logic                    reset_i
  ,input  logic [num_links_p-1:0]  out_v_o
  ,input  flit_t [num_links_p-1:0] out_data_o
  ,input  logic [num_links_p-1:0]  out_ready_and_i
  );

  // reset as seen on the previous edge, state is known after it
  logic reset_r;

  always_ff @(posedge clk_i)
  begin
    reset_r <= reset_i;
  end

  assert property (@(posedge clk_i) (reset_i && reset_r) |-> (out_v_o == '0))
    else $error("out_v_o high during reset");

  // egress has a single FIFO head
  assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(out_v_o))
    else $error("more than one out_v_o high in one cycle");

  for (genvar i = 0; i < num_links_p; i++)
  begin : link
    assert property (@(posedge clk_i) disable iff (reset_i)
      (out_v_o[i] && !out_ready_and_i[i]) |=> (out_v_o[i] && $stable(out_data_o[i])))
      else $error("out_v_o[%0d] dropped or data changed before ready", i);
  end

endmodule

/* sim/wormhole_concentrator_tb.sv */
// wormhole concentrator testbench
// random packet sources on every input link, random back-pressure on the
// outputs, scoreboard queues keyed by source and destination

module wormhole_concentrator_tb
  import wormhole_pkg::*;
  ();

  localparam int num_links_lp    = 4;
  localparam int pkts_per_src_lp = 40;
  localparam int num_pairs_lp    = num_links_lp * num_links_lp;

  logic                     clk;
  logic                     reset;
  logic [num_links_lp-1:0]  in_v;
  flit_t [num_links_lp-1:0] in_data;
  logic [num_links_lp-1:0]  in_ready_and;
  logic [num_links_lp-1:0]  out_v;
  flit_t [num_links_lp-1:0] out_data;
  logic [num_links_lp-1:0]  out_ready_and;

  logic [31:0] lcg_state;
  int          errors;
  int          flits_sent;
  int          flits_recv;
  int          total_flits;
  int          cycle_count;
  int          cycle_limit;

  // packet shapes per source drawn before the run
  len_t pkt_len [num_links_lp][pkts_per_src_lp];
  cid_t pkt_cid [num_links_lp][pkts_per_src_lp];

  // source state
  int    pkt_idx [num_links_lp];
  int    flit_idx [num_links_lp];
  int    gap [num_links_lp];
  int    body_seq [num_links_lp];
  logic  src_v [num_links_lp];
  flit_t src_flit [num_links_lp];

  // sink state with one packet in progress per output
  logic in_pkt [num_links_lp];
  int   cur_src [num_links_lp];
  int   body_left [num_links_lp];

  // expected flits indexed by source * links + destination
  flit_t exp_q [num_pairs_lp][$];

  wormhole_concentrator_top #(.num_links_p(num_links_lp)) dut0
    (.clk_i           (clk)
    ,.reset_i         (reset)
    ,.in_v_i          (in_v)
    ,.in_data_i       (in_data)
    ,.in_ready_and_o  (in_ready_and)
    ,.out_v_o         (out_v)
    ,.out_data_o      (out_data)
    ,.out_ready_and_i (out_ready_and)
    );

  bind wormhole_concentrator_top wormhole_concentrator_assertions
    #(.num_links_p(num_links_p)) assert0
    (.clk_i           (clk_i)
    ,.reset_i         (reset_i)
    ,.out_v_o         (out_v_o)
    ,.out_data_o      (out_data_o)
    ,.out_ready_and_i (out_ready_and_i)
    );

  always #2 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
  end

  // low LCG bits repeat too soon so the upper bits are used
  function automatic int unsigned rand_below(input int unsigned n);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return (lcg_state >> 16) % n;
  endfunction

  // header fields in the low bits over a random upper half
  function automatic flit_t make_header(input int s, input int p);
    flit_t f;
    f = flit_t'(rand_below(65536)) << 16;
    f[cord_lsb_lp +: cord_width_lp] = cord_t'(s);
    f[len_lsb_lp +: len_width_lp]   = pkt_len[s][p];
    f[cid_lsb_lp +: cid_width_lp]   = pkt_cid[s][p];
    return f;
  endfunction

  // source byte, running sequence count, random payload
  function automatic flit_t make_body(input int s, input int seq);
    return {8'(s), 8'(seq), 16'(rand_below(65536))};
  endfunction

  function automatic logic run_done();
    return (flits_sent == total_flits) && (flits_recv >= flits_sent);
  endfunction

  task automatic plan_packets();
    for (int s = 0; s < num_links_lp; s++)
    begin
      for (int p = 0; p < pkts_per_src_lp; p++)
      begin
        pkt_cid[s][p] = cid_t'(rand_below(num_links_lp));
        pkt_len[s][p] = len_t'(rand_below(16));
        total_flits   = total_flits + 1 + int'(pkt_len[s][p]);
      end
    end
  endtask

  task automatic drive_inputs();
    for (int s = 0; s < num_links_lp; s++)
    begin
      if (!src_v[s])
      begin
        if (gap[s] > 0)
          gap[s] = gap[s] - 1;
        else if (pkt_idx[s] < pkts_per_src_lp)
        begin
          src_v[s]    = 1'b1;
          flit_idx[s] = 0;
          src_flit[s] = make_header(s, pkt_idx[s]);
        end
      end
      in_v[s]    = src_v[s];
      in_data[s] = src_flit[s];
    end
    // roughly 70 percent ready per output
    for (int k = 0; k < num_links_lp; k++)
      out_ready_and[k] = (rand_below(10) < 7);
  endtask

  // accepted flits go into the queue of their pair
  task automatic sample_inputs();
    for (int s = 0; s < num_links_lp; s++)
    begin
      if (in_v[s] && in_ready_and[s])
      begin
        exp_q[s * num_links_lp + int'(pkt_cid[s][pkt_idx[s]])].push_back(src_flit[s]);
        flits_sent = flits_sent + 1;
        if (flit_idx[s] == int'(pkt_len[s][pkt_idx[s]]))
        begin
          src_v[s]   = 1'b0;
          pkt_idx[s] = pkt_idx[s] + 1;
          // back to back about half the time
          gap[s]     = (rand_below(2) == 0) ? 0 : int'(rand_below(4));
        end
        else
        begin
          flit_idx[s] = flit_idx[s] + 1;
          src_flit[s] = make_body(s, body_seq[s]);
          body_seq[s] = body_seq[s] + 1;
        end
      end
    end
  endtask

  task automatic compare_pop(input int q, input int k, input flit_t got);
    flit_t exp;
    if (exp_q[q].size() == 0)
    begin
      $display("output %0d delivered flit %h that no source sent to it", k, got);
      errors = errors + 1;
    end
    else
    begin
      exp = exp_q[q].pop_front();
      if (got !== exp)
      begin
        $display("Fail out_data_o[%0d] expected %h got %h", k, exp, got);
        errors = errors + 1;
      end
    end
  endtask

  task automatic check_outputs();
    flit_t got;
    int    src;
    for (int k = 0; k < num_links_lp; k++)
    begin
      if (out_v[k] && out_ready_and[k])
      begin
        got        = out_data[k];
        flits_recv = flits_recv + 1;
        if (!in_pkt[k])
        begin
          // header opens a packet on this output
          src = int'(got[cord_lsb_lp +: cord_width_lp]);
          if (int'(got[cid_lsb_lp +: cid_width_lp]) != k)
          begin
            $display("Fail out_data_o[%0d] cid expected %h got %h",
                     k, cid_t'(k), got[cid_lsb_lp +: cid_width_lp]);
            errors = errors + 1;
          end
          if (src >= num_links_lp)
          begin
            $display("header on output %0d names source %0d, which does not exist", k, src);
            errors = errors + 1;
          end
          else
          begin
            cur_src[k]   = src;
            compare_pop(src * num_links_lp + k, k, got);
            body_left[k] = int'(got[len_lsb_lp +: len_width_lp]);
            in_pkt[k]    = (body_left[k] != 0);
          end
        end
        else
        begin
          // body must come from the same source until the tail
          compare_pop(cur_src[k] * num_links_lp + k, k, got);
          body_left[k] = body_left[k] - 1;
          if (body_left[k] == 0)
            in_pkt[k] = 1'b0;
        end
      end
    end
  endtask

  initial
  begin
    clk           = 1'b0;
    reset         = 1'b1;
    in_v          = '0;
    in_data       = '0;
    out_ready_and = '0;
    lcg_state     = 32'd60895;
    errors        = 0;
    flits_sent    = 0;
    flits_recv    = 0;
    total_flits   = 0;
    cycle_count   = 0;
    for (int s = 0; s < num_links_lp; s++)
    begin
      pkt_idx[s]   = 0;
      flit_idx[s]  = 0;
      body_seq[s]  = 0;
      src_v[s]     = 1'b0;
      src_flit[s]  = '0;
      in_pkt[s]    = 1'b0;
      cur_src[s]   = 0;
      body_left[s] = 0;
    end
    plan_packets();
    for (int s = 0; s < num_links_lp; s++)
      gap[s] = int'(rand_below(4));
    // each flit may wait on arbitration and a 70 percent ready
    cycle_limit = total_flits * 8 + 500;

    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(posedge clk);
    @(negedge clk);

    // first cycle out of reset
    if (out_v !== '0)
    begin
      $display("Fail out_v_o expected %h got %h", {num_links_lp{1'b0}}, out_v);
      errors = errors + 1;
    end
    if (in_ready_and !== '1)
    begin
      $display("Fail in_ready_and_o expected %h got %h", {num_links_lp{1'b1}}, in_ready_and);
      errors = errors + 1;
    end

    while (!run_done() && (cycle_count < cycle_limit))
    begin
      drive_inputs();
      // outputs settle well before the next rising edge
      #1;
      sample_inputs();
      check_outputs();
      @(negedge clk);
    end

    if (!run_done())
    begin
      $display("timeout after %0d cycles, %0d of %0d flits sent, %0d received",
               cycle_count, flits_sent, total_flits, flits_recv);
      errors = errors + 1;
    end
    for (int q = 0; q < num_pairs_lp; q++)
    begin
      if (exp_q[q].size() != 0)
      begin
        $display("%0d flits from source %0d to output %0d never arrived",
                 exp_q[q].size(), q / num_links_lp, q % num_links_lp);
        errors = errors + 1;
      end
    end
    if (flits_recv != total_flits)
    begin
      $display("Fail flits_recv expected %h got %h", total_flits, flits_recv);
      errors = errors + 1;
    end

    $display("errors %0d, flits sent %0d, flits received %0d", errors, flits_sent, flits_recv);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* filelist.f */
logic/wormhole_pkg.sv
logic/wormhole_two_fifo.sv
logic/wormhole_input_control.sv
logic/wormhole_output_control.sv
logic/wormhole_concentrator_in.sv
logic/wormhole_concentrator_out.sv
logic/wormhole_concentrator_top.sv
sim/wormhole_concentrator_assertions.sv
sim/wormhole_concentrator_tb.sv

/* run.sh */
#!/bin/sh
# build the concentrator testbench with Verilator, run it,
# and decide pass or fail from the simulation log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module wormhole_concentrator_tb -o wormhole_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/wormhole_sim > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q "^Test completed successfully$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
